// File: hw/sdram_sched_pkg.sv
// SDRAM scheduler definitions

package sdram_sched_pkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int NUM_PORTS = 2;
  localparam int PORT_W    = 1;
  localparam int BANKS     = 4;
  localparam int BA_W      = 2;
  localparam int ROW_W     = 11;
  localparam int COL_W     = 8;
  localparam int ADDR_W    = 11;
  localparam int DQ_W      = 16;

  ////////////////////
  // Timings in clock cycles
  ////////////////////
  // ACT to RD/WR
  localparam int T_RCD = 2;
  // ACT to PRE
  localparam int T_RAS = 5;
  // PRE to ACT
  localparam int T_RP  = 2;
  // ACT to ACT, same bank
  localparam int T_RC  = 7;
  // Write recovery before PRE
  localparam int T_WR  = 2;
  // REF to next ACT or REF
  localparam int T_RFC = 7;
  // RD to data on DQ
  localparam int CL    = 3;

  // Short on purpose so a simulation sees several refreshes
  localparam int REF_INTERVAL = 200;

  // Encoded as {RAS_n, CAS_n, WE_n}
  typedef enum logic [2:0] {
    CMD_REF = 3'b001,
    CMD_PRE = 3'b010,
    CMD_ACT = 3'b011,
    CMD_WR  = 3'b100,
    CMD_RD  = 3'b101,
    CMD_NOP = 3'b111
  } sdram_cmd_e;

  // Address pins, row on ACT, column plus A10 on RD, WR and PRE
  typedef union packed {
    logic [ADDR_W-1:0] row;
    struct packed {
      logic                      ap;
      logic [ADDR_W-COL_W-2:0]   pad;
      logic [COL_W-1:0]          col;
    } cas;
  } sdram_addr_u;

endpackage

// File: hw/port_arbiter.sv
// Fixed priority port arbiter
`timescale 1ns/1ps

module port_arbiter
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i     [NUM_PORTS],
  input  logic              we_i      [NUM_PORTS],
  input  logic [BA_W-1:0]   ba_i      [NUM_PORTS],
  input  logic [ROW_W-1:0]  row_i     [NUM_PORTS],
  input  logic [COL_W-1:0]  col_i     [NUM_PORTS],
  input  logic [DQ_W-1:0]   wdata_i   [NUM_PORTS],
  input  logic              grant_i,
  output logic              rdy_o     [NUM_PORTS],
  output logic              sel_valid_o,
  output logic [PORT_W-1:0] sel_port_o,
  output logic              sel_we_o,
  output logic [BA_W-1:0]   sel_ba_o,
  output logic [ROW_W-1:0]  sel_row_o,
  output logic [COL_W-1:0]  sel_col_o,
  output logic [DQ_W-1:0]   sel_wdata_o
);

  logic              any_req;
  logic [PORT_W-1:0] pick;

  // Scan downwards so port 0 wins
  always_comb
  begin
    any_req = 1'b0;
    pick    = '0;
    for (int p = NUM_PORTS - 1; p >= 0; p--)
    begin
      if (req_i[p])
      begin
        any_req = 1'b1;
        pick    = PORT_W'(p);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      sel_valid_o <= 1'b0;
      sel_port_o  <= '0;
    end
    else if (sel_valid_o)
    begin
      if (grant_i)
        sel_valid_o <= 1'b0;
    end
    else if (any_req)
    begin
      sel_valid_o <= 1'b1;
      sel_port_o  <= pick;
    end
  end

  // Request payload, held until grant
  always_ff @(posedge clk_i)
  begin
    if (!sel_valid_o && any_req)
    begin
      sel_we_o    <= we_i[pick];
      sel_ba_o    <= ba_i[pick];
      sel_row_o   <= row_i[pick];
      sel_col_o   <= col_i[pick];
      sel_wdata_o <= wdata_i[pick];
    end
  end

  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
      rdy_o[p] = grant_i && sel_valid_o && (sel_port_o == PORT_W'(p));
  end

endmodule

// File: hw/bank_tracker.sv
// Bank state tracker
`timescale 1ns/1ps

module bank_tracker
  import sdram_sched_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             act_i,
  input  logic             pre_i,
  input  logic             wr_i,
  input  logic [ROW_W-1:0] act_row_i,
  input  logic [ROW_W-1:0] sel_row_i,
  output logic             open_o,
  output logic             row_hit_o,
  output logic             act_ok_o,
  output logic             rw_ok_o,
  output logic             pre_ok_o
);

  // Slots 0 tRCD, 1 tRAS, 2 tRC, 3 tRP, 4 tWR
  logic [$clog2(T_RC)-1:0] cnt [5];
  logic [4:0]              done;
  logic [4:0]              load;
  logic [ROW_W-1:0]        row_q;

  // One short of the full time, the done flag adds the last cycle
  function automatic logic [$clog2(T_RC)-1:0] reload(input int slot);
    int t;
    case (slot)
      0:       t = T_RCD;
      1:       t = T_RAS;
      2:       t = T_RC;
      3:       t = T_RP;
      default: t = T_WR;
    endcase
    return ($clog2(T_RC))'(t - 1);
  endfunction

  assign load = {wr_i, pre_i, act_i, act_i, act_i};

  ////////////////////
  // Timers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      done <= '1;
      for (int i = 0; i < 5; i++)
        cnt[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 5; i++)
      begin
        if (load[i])
        begin
          cnt[i]  <= reload(i);
          done[i] <= 1'b0;
        end
        else if (!done[i])
        begin
          cnt[i]  <= cnt[i] - 1'b1;
          done[i] <= (cnt[i] == 1);
        end
      end
    end
  end

  ////////////////////
  // Open row
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      open_o <= 1'b0;
    else if (act_i)
      open_o <= 1'b1;
    else if (pre_i)
      open_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (act_i)
      row_q <= act_row_i;
  end

  assign row_hit_o = open_o && (row_q == sel_row_i);

  // Permissions
  assign act_ok_o = !open_o && done[3] && done[2];
  assign rw_ok_o  = open_o && done[0];
  assign pre_ok_o = open_o && done[1] && done[4];

endmodule

// File: hw/cmd_issuer.sv
// SDRAM command issuer
`timescale 1ns/1ps

module cmd_issuer
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              sel_valid_i,
  input  logic [PORT_W-1:0] sel_port_i,
  input  logic              sel_we_i,
  input  logic [BA_W-1:0]   sel_ba_i,
  input  logic [COL_W-1:0]  sel_col_i,
  input  logic [ROW_W-1:0]  sel_row_i,
  input  logic [DQ_W-1:0]   sel_wdata_i,
  input  logic [BANKS-1:0]  open_i,
  input  logic [BANKS-1:0]  row_hit_i,
  input  logic [BANKS-1:0]  act_ok_i,
  input  logic [BANKS-1:0]  rw_ok_i,
  input  logic [BANKS-1:0]  pre_ok_i,
  output logic              grant_o,
  output logic [BANKS-1:0]  act_o,
  output logic [BANKS-1:0]  pre_o,
  output logic [BANKS-1:0]  wr_o,
  output logic [ROW_W-1:0]  act_row_o,
  output logic              rd_issue_o,
  output logic [PORT_W-1:0] rd_port_o,
  output sdram_cmd_e        sdram_cmd_o,
  output logic [BA_W-1:0]   sdram_ba_o,
  output sdram_addr_u       sdram_addr_o,
  output logic [DQ_W-1:0]   sdram_dq_o,
  output logic              sdram_dqoe_o
);

  logic [$clog2(REF_INTERVAL)-1:0] ref_cnt;
  logic                            ref_pend;
  logic [$clog2(T_RFC)-1:0]        rfc_cnt;
  logic                            rfc_done;
  // FSM, low is normal operation and high is refresh
  logic                            in_ref_q;
  logic                            in_ref_d;
  sdram_cmd_e                      cmd_d;
  logic [BA_W-1:0]                 ba_d;
  sdram_addr_u                     addr_d;
  logic                            banks_closable;

  // Every open bank may be precharged now
  assign banks_closable = &(~open_i | pre_ok_i);
  assign act_row_o      = sel_row_i;

  ////////////////////
  // Refresh timers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ref_cnt  <= ($clog2(REF_INTERVAL))'(REF_INTERVAL - 1);
      ref_pend <= 1'b0;
    end
    else
    begin
      if (ref_cnt == 0)
        ref_cnt <= ($clog2(REF_INTERVAL))'(REF_INTERVAL - 1);
      else
        ref_cnt <= ref_cnt - 1'b1;
      // Only one refresh can be owed
      if (ref_cnt == 0)
        ref_pend <= 1'b1;
      else if (cmd_d == CMD_REF)
        ref_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rfc_cnt  <= '0;
      rfc_done <= 1'b1;
    end
    else if (cmd_d == CMD_REF)
    begin
      rfc_cnt  <= ($clog2(T_RFC))'(T_RFC - 1);
      rfc_done <= 1'b0;
    end
    else if (!rfc_done)
    begin
      rfc_cnt  <= rfc_cnt - 1'b1;
      rfc_done <= (rfc_cnt == 1);
    end
  end

  ////////////////////
  // Command decision
  ////////////////////
  always_comb
  begin
    in_ref_d = in_ref_q;
    cmd_d    = CMD_NOP;
    ba_d     = sel_ba_i;
    addr_d   = '0;
    act_o    = '0;
    pre_o    = '0;
    wr_o     = '0;
    if (in_ref_q)
    begin
      // All banks closed, wait out tRP, tRC and tRFC
      if (&act_ok_i && rfc_done)
      begin
        cmd_d    = CMD_REF;
        in_ref_d = 1'b0;
      end
    end
    else if (ref_pend)
    begin
      if (open_i == '0)
        in_ref_d = 1'b1;
      else if (banks_closable)
      begin
        cmd_d         = CMD_PRE;
        addr_d.cas.ap = 1'b1;
        pre_o         = '1;
        in_ref_d      = 1'b1;
      end
    end
    // Held request, skip the cycle its RD or WR is already on the pins
    else if (sel_valid_i && !grant_o)
    begin
      if (row_hit_i[sel_ba_i])
      begin
        if (rw_ok_i[sel_ba_i])
        begin
          cmd_d          = sel_we_i ? CMD_WR : CMD_RD;
          addr_d.cas.col = sel_col_i;
          wr_o[sel_ba_i] = sel_we_i;
        end
      end
      else if (open_i[sel_ba_i])
      begin
        // Row miss, close the old row first
        if (pre_ok_i[sel_ba_i])
        begin
          cmd_d           = CMD_PRE;
          pre_o[sel_ba_i] = 1'b1;
        end
      end
      else if (act_ok_i[sel_ba_i] && rfc_done)
      begin
        cmd_d           = CMD_ACT;
        addr_d.row      = sel_row_i;
        act_o[sel_ba_i] = 1'b1;
      end
    end
  end

  ////////////////////
  // Pin registers
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      in_ref_q     <= 1'b0;
      sdram_cmd_o  <= CMD_NOP;
      sdram_dqoe_o <= 1'b0;
      grant_o      <= 1'b0;
      rd_issue_o   <= 1'b0;
    end
    else
    begin
      in_ref_q     <= in_ref_d;
      sdram_cmd_o  <= cmd_d;
      sdram_dqoe_o <= (cmd_d == CMD_WR);
      grant_o      <= (cmd_d == CMD_WR) || (cmd_d == CMD_RD);
      rd_issue_o   <= (cmd_d == CMD_RD);
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= ba_d;
    sdram_addr_o <= addr_d;
    sdram_dq_o   <= sel_wdata_i;
    rd_port_o    <= sel_port_i;
  end

endmodule

// File: hw/rd_data_router.sv
// Read data return router
`timescale 1ns/1ps

module rd_data_router
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rd_issue_i,
  input  logic [PORT_W-1:0] rd_port_i,
  output logic              rd_valid_o [NUM_PORTS]
);

  // One stage per cycle of CAS latency
  logic [CL-1:0]     vld_q;
  logic [PORT_W-1:0] port_q [CL];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      vld_q <= '0;
    else
      vld_q <= {vld_q[CL-2:0], rd_issue_i};
  end

  // Port tags follow the valid bits
  always_ff @(posedge clk_i)
  begin
    port_q[0] <= rd_port_i;
    for (int i = 1; i < CL; i++)
      port_q[i] <= port_q[i-1];
  end

  // Last stage lines up with data on DQ
  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
      rd_valid_o[p] = vld_q[CL-1] && (port_q[CL-1] == PORT_W'(p));
  end

endmodule

// File: hw/sdram_sched_top.sv
// SDRAM command scheduler top
`timescale 1ns/1ps

module sdram_sched_top
  import sdram_sched_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i      [NUM_PORTS],
  input  logic              we_i       [NUM_PORTS],
  input  logic [BA_W-1:0]   ba_i       [NUM_PORTS],
  input  logic [ROW_W-1:0]  row_i      [NUM_PORTS],
  input  logic [COL_W-1:0]  col_i      [NUM_PORTS],
  input  logic [DQ_W-1:0]   wdata_i    [NUM_PORTS],
  output logic              rdy_o      [NUM_PORTS],
  output logic              rd_valid_o [NUM_PORTS],
  output logic [DQ_W-1:0]   rdata_o,
  output sdram_cmd_e        sdram_cmd_o,
  output logic [BA_W-1:0]   sdram_ba_o,
  output sdram_addr_u       sdram_addr_o,
  output logic [DQ_W-1:0]   sdram_dq_o,
  output logic              sdram_dqoe_o,
  input  logic [DQ_W-1:0]   sdram_dq_i
);

  logic              sel_valid;
  logic [PORT_W-1:0] sel_port;
  logic              sel_we;
  logic [BA_W-1:0]   sel_ba;
  logic [ROW_W-1:0]  sel_row;
  logic [COL_W-1:0]  sel_col;
  logic [DQ_W-1:0]   sel_wdata;
  logic              grant;
  logic [BANKS-1:0]  bank_open;
  logic [BANKS-1:0]  row_hit;
  logic [BANKS-1:0]  act_ok;
  logic [BANKS-1:0]  rw_ok;
  logic [BANKS-1:0]  pre_ok;
  logic [BANKS-1:0]  act;
  logic [BANKS-1:0]  pre;
  logic [BANKS-1:0]  wr;
  logic [ROW_W-1:0]  act_row;
  logic              rd_issue;
  logic [PORT_W-1:0] rd_port;

  port_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .we_i        (we_i),
    .ba_i        (ba_i),
    .row_i       (row_i),
    .col_i       (col_i),
    .wdata_i     (wdata_i),
    .grant_i     (grant),
    .rdy_o       (rdy_o),
    .sel_valid_o (sel_valid),
    .sel_port_o  (sel_port),
    .sel_we_o    (sel_we),
    .sel_ba_o    (sel_ba),
    .sel_row_o   (sel_row),
    .sel_col_o   (sel_col),
    .sel_wdata_o (sel_wdata)
  );

  for (genvar b = 0; b < BANKS; b++)
  begin : g_bank
    bank_tracker u_tracker (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .act_i     (act[b]),
      .pre_i     (pre[b]),
      .wr_i      (wr[b]),
      .act_row_i (act_row),
      .sel_row_i (sel_row),
      .open_o    (bank_open[b]),
      .row_hit_o (row_hit[b]),
      .act_ok_o  (act_ok[b]),
      .rw_ok_o   (rw_ok[b]),
      .pre_ok_o  (pre_ok[b])
    );
  end

  cmd_issuer u_issuer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sel_valid_i  (sel_valid),
    .sel_port_i   (sel_port),
    .sel_we_i     (sel_we),
    .sel_ba_i     (sel_ba),
    .sel_col_i    (sel_col),
    .sel_row_i    (sel_row),
    .sel_wdata_i  (sel_wdata),
    .open_i       (bank_open),
    .row_hit_i    (row_hit),
    .act_ok_i     (act_ok),
    .rw_ok_i      (rw_ok),
    .pre_ok_i     (pre_ok),
    .grant_o      (grant),
    .act_o        (act),
    .pre_o        (pre),
    .wr_o         (wr),
    .act_row_o    (act_row),
    .rd_issue_o   (rd_issue),
    .rd_port_o    (rd_port),
    .sdram_cmd_o  (sdram_cmd_o),
    .sdram_ba_o   (sdram_ba_o),
    .sdram_addr_o (sdram_addr_o),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o)
  );

  rd_data_router u_router (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_issue_i (rd_issue),
    .rd_port_i  (rd_port),
    .rd_valid_o (rd_valid_o)
  );

  // Every port sees DQ, rd_valid_o picks the owner
  assign rdata_o = sdram_dq_i;

endmodule

// File: bench/sdram_sched_asserts.sv
// SDRAM scheduler protocol assertions
`timescale 1ns/1ps

module sdram_sched_asserts
  import sdram_sched_pkg::*;
(
  input logic            clk_i,
  input logic            rst_ni,
  input logic            rdy_i [NUM_PORTS],
  input sdram_cmd_e      sdram_cmd_i,
  input logic            sdram_dqoe_i,
  input logic [BA_W-1:0] sdram_ba_i,
  input sdram_addr_u     sdram_addr_i
);

  logic [NUM_PORTS-1:0] rdy_vec;
  // Banks activated on the pins and not yet precharged
  logic [BANKS-1:0]     act_seen;
  int                   fail_cnt = 0;

  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
      rdy_vec[p] = rdy_i[p];
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      act_seen <= '0;
    else if (sdram_cmd_i == CMD_ACT)
      act_seen[sdram_ba_i] <= 1'b1;
    else if (sdram_cmd_i == CMD_PRE && sdram_addr_i.cas.ap)
      act_seen <= '0;
    else if (sdram_cmd_i == CMD_PRE)
      act_seen[sdram_ba_i] <= 1'b0;
  end

  a_one_rdy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rdy_vec))
    else
    begin
      fail_cnt++;
      $error("more than one rdy_o high");
    end

  a_dqoe_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdram_dqoe_i |-> sdram_cmd_i == CMD_WR)
    else
    begin
      fail_cnt++;
      $error("DQ driven outside a WR");
    end

  // REF only with every bank precharged
  a_ref_closed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdram_cmd_i == CMD_REF |-> act_seen == '0)
    else
    begin
      fail_cnt++;
      $error("REF while a bank is open");
    end

endmodule

// File: bench/tb_sdram_sched.sv
// SDRAM scheduler testbench
`timescale 1ns/1ps

module tb_sdram_sched
  import sdram_sched_pkg::*;
();

  localparam int NUM_STIM        = 16;
  localparam int PASSES          = 3;
  localparam int ENTRY_BOUND     = 60;
  localparam int REF_SLACK       = 40;
  localparam int WATCHDOG_CYCLES = (PASSES * NUM_STIM + 2) * ENTRY_BOUND
                                   + (PASSES + 2) * REF_INTERVAL + 100;

  // Entry is {port, we, bank, row, col}
  localparam logic [22:0] STIM [NUM_STIM] = '{
    {1'b0, 1'b1, 2'd0, 11'd5,    8'd3},   {1'b1, 1'b1, 2'd0, 11'd5,    8'd4},
    {1'b0, 1'b1, 2'd1, 11'd9,    8'd10},  {1'b1, 1'b1, 2'd2, 11'd100,  8'd0},
    {1'b0, 1'b1, 2'd3, 11'd2047, 8'd255}, {1'b1, 1'b1, 2'd0, 11'd6,    8'd3},
    {1'b0, 1'b1, 2'd1, 11'd9,    8'd11},  {1'b1, 1'b1, 2'd2, 11'd101,  8'd7},
    {1'b1, 1'b0, 2'd0, 11'd5,    8'd3},   {1'b0, 1'b0, 2'd0, 11'd5,    8'd4},
    {1'b1, 1'b0, 2'd1, 11'd9,    8'd10},  {1'b0, 1'b0, 2'd2, 11'd100,  8'd0},
    {1'b1, 1'b0, 2'd3, 11'd2047, 8'd255}, {1'b0, 1'b0, 2'd0, 11'd6,    8'd3},
    {1'b1, 1'b0, 2'd1, 11'd9,    8'd11},  {1'b0, 1'b0, 2'd2, 11'd101,  8'd7}
  };

  logic             clk_i;
  logic             rst_ni;
  logic             req    [NUM_PORTS];
  logic             we     [NUM_PORTS];
  logic [BA_W-1:0]  ba     [NUM_PORTS];
  logic [ROW_W-1:0] row    [NUM_PORTS];
  logic [COL_W-1:0] col    [NUM_PORTS];
  logic [DQ_W-1:0]  wdata  [NUM_PORTS];
  logic             rdy    [NUM_PORTS];
  logic             rd_vld [NUM_PORTS];
  logic [DQ_W-1:0]  rdata;
  sdram_cmd_e       cmd;
  logic [BA_W-1:0]  cmd_ba;
  sdram_addr_u      cmd_addr;
  logic [DQ_W-1:0]  dq_out;
  logic             dqoe;
  logic [DQ_W-1:0]  dq_in;

  logic [31:0]      lcg_state = 32'h3abe;
  int               errors    = 0;
  int               checks    = 0;
  int               reads     = 0;
  logic [DQ_W-1:0]  shadow [int];
  logic [DQ_W-1:0]  exp_q [NUM_PORTS][$];

  // SDRAM model state, times in cycles after reset
  int               t = 0;
  int               ref_count = 0;
  int               last_ref = -T_RFC;
  int               last_act [BANKS];
  int               last_pre [BANKS];
  int               last_wr  [BANKS];
  logic             is_open  [BANKS];
  logic [ROW_W-1:0] open_row [BANKS];
  logic [DQ_W-1:0]  mem [int];
  logic [DQ_W-1:0]  rd_slot [CL];

  sdram_sched_top dut0 (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req), .we_i(we), .ba_i(ba),
    .row_i(row), .col_i(col), .wdata_i(wdata), .rdy_o(rdy), .rd_valid_o(rd_vld),
    .rdata_o(rdata), .sdram_cmd_o(cmd), .sdram_ba_o(cmd_ba), .sdram_addr_o(cmd_addr),
    .sdram_dq_o(dq_out), .sdram_dqoe_o(dqoe), .sdram_dq_i(dq_in)
  );

  bind sdram_sched_top sdram_sched_asserts u_asserts (
    .clk_i(clk_i), .rst_ni(rst_ni), .rdy_i(rdy_o), .sdram_cmd_i(sdram_cmd_o),
    .sdram_dqoe_i(sdram_dqoe_o), .sdram_ba_i(sdram_ba_o), .sdram_addr_i(sdram_addr_o)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int addr_key(logic [BA_W-1:0] b, logic [ROW_W-1:0] r,
                                  logic [COL_W-1:0] c);
    return int'({b, r, c});
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic violation(string msg);
    errors++;
    $display("Protocol error at cycle %0d: %s", t, msg);
  endtask

  task automatic end_test(string name, int err_before);
    $display("test %-10s %s", name, (errors == err_before) ? "ok" : "had errors");
  endtask

  ////////////////////
  // Clock and watchdog
  ////////////////////
  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired, the scheduler stopped answering requests");
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // SDRAM model
  ////////////////////
  always @(posedge clk_i)
  begin
    dq_in <= rd_slot[0];
    for (int i = 0; i < CL - 1; i++)
      rd_slot[i] <= rd_slot[i+1];
    rd_slot[CL-1] <= '0;
  end

  always @(negedge clk_i)
  begin
    if (rst_ni)
    begin
      t++;
      case (cmd)
        CMD_ACT:
        begin
          if (is_open[cmd_ba]) violation("ACT to an open bank");
          if (t - last_pre[cmd_ba] < T_RP) violation("ACT inside tRP");
          if (t - last_act[cmd_ba] < T_RC) violation("ACT inside tRC");
          if (t - last_ref < T_RFC) violation("ACT inside tRFC");
          is_open[cmd_ba]  = 1'b1;
          open_row[cmd_ba] = cmd_addr.row;
          last_act[cmd_ba] = t;
        end
        CMD_RD, CMD_WR:
        begin
          if (!is_open[cmd_ba]) violation("RD or WR to an idle bank");
          if (t - last_act[cmd_ba] < T_RCD) violation("RD or WR inside tRCD");
          if (cmd == CMD_WR)
          begin
            check("sdram_dqoe_o", dqoe, 1);
            mem[addr_key(cmd_ba, open_row[cmd_ba], cmd_addr.cas.col)] = dq_out;
            last_wr[cmd_ba] = t;
          end
          else
            rd_slot[CL-1] <= mem.exists(addr_key(cmd_ba, open_row[cmd_ba], cmd_addr.cas.col))
                             ? mem[addr_key(cmd_ba, open_row[cmd_ba], cmd_addr.cas.col)] : '0;
        end
        CMD_PRE:
        begin
          for (int b = 0; b < BANKS; b++)
          begin
            if ((cmd_addr.cas.ap || b == int'(cmd_ba)) && is_open[b])
            begin
              if (t - last_act[b] < T_RAS) violation("PRE inside tRAS");
              if (t - last_wr[b] < T_WR) violation("PRE inside tWR");
              is_open[b]  = 1'b0;
              last_pre[b] = t;
            end
          end
        end
        CMD_REF:
        begin
          for (int b = 0; b < BANKS; b++)
          begin
            if (is_open[b]) violation("REF with a bank open");
            if (t - last_pre[b] < T_RP) violation("REF inside tRP");
          end
          if (t - last_ref < T_RFC) violation("REF inside tRFC");
          if (t - last_ref > REF_INTERVAL + REF_SLACK) violation("refresh came too late");
          last_ref = t;
          ref_count++;
        end
        default: ;
      endcase
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        if (rd_vld[p])
        begin
          if (exp_q[p].size() == 0)
            violation("read data returned to a port with no read pending");
          else
          begin
            check("rdata_o", rdata, exp_q[p].pop_front());
            reads++;
          end
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic record_request(int p);
    if (we[p])
      shadow[addr_key(ba[p], row[p], col[p])] = wdata[p];
    else
      exp_q[p].push_back(shadow.exists(addr_key(ba[p], row[p], col[p]))
                         ? shadow[addr_key(ba[p], row[p], col[p])] : '0);
  endtask

  task automatic wait_rdy(int p);
    do
      @(negedge clk_i);
    while (!rdy[p]);
    record_request(p);
  endtask

  task automatic drive_port(int p, logic w, logic [BA_W-1:0] b, logic [ROW_W-1:0] r,
                            logic [COL_W-1:0] c);
    req[p]   <= 1'b1;
    we[p]    <= w;
    ba[p]    <= b;
    row[p]   <= r;
    col[p]   <= c;
    wdata[p] <= DQ_W'(lcg_next() >> 8);
  endtask

  task automatic apply_entry(logic [22:0] e);
    int p;
    p = int'(e[22]);
    @(posedge clk_i);
    drive_port(p, e[21], e[20:19], e[18:8], e[7:0]);
    wait_rdy(p);
    @(posedge clk_i);
    req[p] <= 1'b0;
  endtask

  initial
  begin
    int err0;
    rst_ni = 1'b0;
    dq_in  = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p]   = 1'b0;
      we[p]    = 1'b0;
      ba[p]    = '0;
      row[p]   = '0;
      col[p]   = '0;
      wdata[p] = '0;
    end
    for (int b = 0; b < BANKS; b++)
    begin
      last_act[b] = -100;
      last_pre[b] = -100;
      last_wr[b]  = -100;
      is_open[b]  = 1'b0;
    end
    for (int i = 0; i < CL; i++)
      rd_slot[i] = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    err0 = errors;
    @(negedge clk_i);
    check("sdram_cmd_o", cmd, CMD_NOP);
    check("sdram_dqoe_o", dqoe, 0);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      check("rdy_o", rdy[p], 0);
      check("rd_valid_o", rd_vld[p], 0);
    end
    end_test("reset", err0);

    for (int pass = 0; pass < PASSES; pass++)
    begin
      err0 = errors;
      for (int i = 0; i < NUM_STIM; i++)
        apply_entry(STIM[i]);
      repeat (REF_INTERVAL) @(posedge clk_i);
      end_test($sformatf("pass%0d", pass), err0);
    end

    // Both ports in the same cycle on an idle scheduler
    err0 = errors;
    @(posedge clk_i);
    drive_port(0, 1'b1, 2'd3, 11'd40, 8'd1);
    drive_port(1, 1'b1, 2'd2, 11'd41, 8'd2);
    do
      @(negedge clk_i);
    while (!rdy[0] && !rdy[1]);
    check("rdy_o[0]", rdy[0], 1);
    check("rdy_o[1]", rdy[1], 0);
    record_request(0);
    @(posedge clk_i);
    req[0] <= 1'b0;
    wait_rdy(1);
    @(posedge clk_i);
    req[1] <= 1'b0;
    end_test("priority", err0);

    err0 = errors;
    repeat (REF_INTERVAL + REF_SLACK) @(posedge clk_i);
    @(negedge clk_i);
    if (t - last_ref > REF_INTERVAL + REF_SLACK)
      violation("refresh stopped");
    check("refresh count ok", ref_count >= (t / (REF_INTERVAL + REF_SLACK)), 1);
    check("pending reads port 0", exp_q[0].size(), 0);
    check("pending reads port 1", exp_q[1].size(), 0);
    end_test("refresh", err0);

    $display("checks %0d, reads %0d, refreshes %0d, errors %0d, assertion failures %0d",
             checks, reads, ref_count, errors, dut0.u_asserts.fail_cnt);
    if (errors == 0 && dut0.u_asserts.fail_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tb.f
hw/sdram_sched_pkg.sv
hw/port_arbiter.sv
hw/bank_tracker.sv
hw/cmd_issuer.sv
hw/rd_data_router.sv
hw/sdram_sched_top.sv
bench/sdram_sched_asserts.sv
bench/tb_sdram_sched.sv

// File: run_verilator.sh
#!/bin/sh
# Build and run the SDRAM scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_sdram_sched \
  -f tb.f -o sim_sdram_sched

out=$(./obj_dir/sim_sdram_sched)
echo "$out"

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
